// File: Bender.yml
package:
  name: dbg_hwbrk

sources:
  - dbg_pkg.sv
  - dbg_hwbrk.sv
  - dbg_ctrl.sv
  - dbg_top.sv
  - target: simulation
    files:
      - tb_dbg.sv

// File: dbg_ctrl.sv
`default_nettype none

module dbg_ctrl (
  input  logic                            mclk,
  input  logic                            por,
  input  logic [5:0]                      dbg_addr,     // Host register address
  input  logic [15:0]                     dbg_din,
  input  logic                            dbg_wr,       // Write strobe
  input  logic                            dbg_rd,       // Read strobe
  input  logic [dbg_pkg::num_hwbrk-1:0]    brk_halt,     // Halt pulse per unit
  input  logic [dbg_pkg::num_hwbrk-1:0]    brk_pnd,      // Pending per unit
  input  logic [16*dbg_pkg::num_hwbrk-1:0] brk_dout,     // Unit read data, packed
  output logic [4*dbg_pkg::num_hwbrk-1:0]  brk_reg_rd,
  output logic [4*dbg_pkg::num_hwbrk-1:0]  brk_reg_wr,
  output logic [15:0]                     dbg_dout,
  output logic                            dbg_halt_cmd  // CPU halt request
);

  //==========================================================
  // Declarations
  //==========================================================
  logic [4*dbg_pkg::num_hwbrk-1:0] brk_sel;     // Unit register hit

  logic        cpu_ctl_sel;
  logic        cpu_stat_sel;
  logic        cpu_ctl_wr;

  logic        halt_state;
  logic        halt_set;
  logic        halt_clr;

  logic [15:0] cpu_ctl_val;
  logic [15:0] cpu_stat_val;
  logic [15:0] brk_rd_or;
  logic [15:0] own_rd;

  //==========================================================
  // Address decode
  //==========================================================
  // Unit registers are contiguous from the base address
  always_comb begin
    for (int i = 0; i < 4*dbg_pkg::num_hwbrk; i++) begin
      brk_sel[i] = (dbg_addr == 6'(dbg_pkg::brk_base_addr + i));
    end
  end

  assign cpu_ctl_sel  = (dbg_addr == dbg_pkg::cpu_ctl_addr);
  assign cpu_stat_sel = (dbg_addr == dbg_pkg::cpu_stat_addr);

  assign brk_reg_wr = brk_sel & {4*dbg_pkg::num_hwbrk{dbg_wr}};
  assign brk_reg_rd = brk_sel & {4*dbg_pkg::num_hwbrk{dbg_rd}};

  assign cpu_ctl_wr = dbg_wr & cpu_ctl_sel;

  //==========================================================
  // Halt state
  //==========================================================
  // HALT beats RUN when both bits are written
  assign halt_set = (|brk_halt) | (cpu_ctl_wr & dbg_din[dbg_pkg::cpu_ctl_halt]);
  assign halt_clr = cpu_ctl_wr & dbg_din[dbg_pkg::cpu_ctl_run];

  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      halt_state <= 1'b0;
    end else if (halt_set) begin
      halt_state <= 1'b1;
    end else if (halt_clr) begin
      halt_state <= 1'b0;
    end
  end

  assign dbg_halt_cmd = halt_state;

  //==========================================================
  // Local read values
  //==========================================================
  // CPU_CTL mirrors the halt request on its HALT bit
  always_comb begin
    cpu_ctl_val = 16'h0000;
    cpu_ctl_val[dbg_pkg::cpu_ctl_halt] = halt_state;
  end

  always_comb begin
    cpu_stat_val = 16'h0000;
    cpu_stat_val[0] = halt_state;                  // Halted
    cpu_stat_val[2] = |brk_pnd;                    // Any unit pending
    cpu_stat_val[4 +: dbg_pkg::num_hwbrk] = brk_pnd;
  end

  assign own_rd = (cpu_ctl_val  & {16{dbg_rd & cpu_ctl_sel}}) |
                  (cpu_stat_val & {16{dbg_rd & cpu_stat_sel}});

  //==========================================================
  // Read data merge
  //==========================================================
  // Units drive zero when not selected
  always_comb begin
    brk_rd_or = 16'h0000;
    for (int n = 0; n < dbg_pkg::num_hwbrk; n++) begin
      brk_rd_or = brk_rd_or | brk_dout[16*n +: 16];
    end
  end

  assign dbg_dout = own_rd | brk_rd_or;

  //==========================================================
  // Assertions
  //==========================================================
  a_sel_onehot : assert property (@(posedge mclk) disable iff (por)
    $onehot0({brk_reg_wr, brk_reg_rd, cpu_ctl_sel, cpu_stat_sel}));

  // Idle bus reads as zero, units included
  a_dout_idle : assert property (@(posedge mclk) disable iff (por)
    !dbg_rd |-> (dbg_dout == 16'h0000));

endmodule

`default_nettype wire

// File: dbg_hwbrk.sv
`default_nettype none

module dbg_hwbrk (
  input  logic        mclk,
  input  logic        por,
  input  logic [3:0]  brk_reg_rd,                 // One-hot register read select
  input  logic [3:0]  brk_reg_wr,                 // One-hot register write select
  input  logic [15:0] dbg_din,                    // Host write data
  input  logic [15:0] eu_mab,                     // Execution unit address
  input  logic        eu_mb_en,
  input  logic [1:0]  eu_mb_wr,                   // Byte write enables
  input  logic        exec_done,                  // Instruction finished
  input  logic        fe_mb_en,                   // Frontend fetch
  input  logic [15:0] pc,
  output logic        brk_halt,                   // Halt request pulse
  output logic        brk_pnd,                    // Any status flag set
  output logic [15:0] brk_dout                    // Zero unless selected
);

  //==========================================================
  // Declarations
  //==========================================================
  dbg_pkg::dbg_word_u din_w;                      // Host data, decoded view

  logic [4:0]  brk_ctl;
  logic [5:0]  brk_stat;
  logic [15:0] brk_addr0;
  logic [15:0] brk_addr1;

  logic [5:0]  stat_set;
  logic [5:0]  stat_clr;

  logic        range_mode;
  logic        fetch_mode;
  logic        d_wr;
  logic        fe_mb_en_q;
  logic [2:0]  d_rd_trig;                         // {range, addr1, addr0}

  logic        equ_d_addr0, equ_d_addr1, equ_d_range;
  logic        equ_i_addr0, equ_i_addr1, equ_i_range;
  logic        d_addr0_wr, d_addr1_wr, d_range_wr;
  logic        d_addr0_rd, d_addr1_rd, d_range_rd;
  logic        i_addr0_rd, i_addr1_rd, i_range_rd;

  assign din_w.raw = dbg_din;

  //==========================================================
  // Configuration registers
  //==========================================================
  // Control, range bit dropped when not built in
  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      brk_ctl <= 5'h00;
    end else if (brk_reg_wr[dbg_pkg::brk_ctl_idx]) begin
      brk_ctl <= {din_w.ctl.range_mode & dbg_pkg::hwbrk_range_en,
                  din_w.ctl.inst_en,
                  din_w.ctl.break_en,
                  din_w.ctl.access_mode};
    end
  end

  // Clear mask from the stat view
  assign stat_clr = {din_w.stat.range_wr, din_w.stat.range_rd,
                     din_w.stat.addr1_wr, din_w.stat.addr1_rd,
                     din_w.stat.addr0_wr, din_w.stat.addr0_rd};

  // Sticky status, a new set beats a clear
  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      brk_stat <= 6'h00;
    end else if (brk_reg_wr[dbg_pkg::brk_stat_idx]) begin
      brk_stat <= (brk_stat & ~stat_clr) | stat_set;
    end else begin
      brk_stat <= brk_stat | stat_set;
    end
  end

  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      brk_addr0 <= 16'h0000;
    end else if (brk_reg_wr[dbg_pkg::brk_addr0_idx]) begin
      brk_addr0 <= dbg_din;
    end
  end

  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      brk_addr1 <= 16'h0000;
    end else if (brk_reg_wr[dbg_pkg::brk_addr1_idx]) begin
      brk_addr1 <= dbg_din;
    end
  end

  //==========================================================
  // Read data
  //==========================================================
  assign brk_dout = ({11'h000, brk_ctl}  & {16{brk_reg_rd[dbg_pkg::brk_ctl_idx]}})   |
                    ({10'h000, brk_stat} & {16{brk_reg_rd[dbg_pkg::brk_stat_idx]}})  |
                    (brk_addr0           & {16{brk_reg_rd[dbg_pkg::brk_addr0_idx]}}) |
                    (brk_addr1           & {16{brk_reg_rd[dbg_pkg::brk_addr1_idx]}});

  //==========================================================
  // Comparators
  //==========================================================
  assign range_mode = brk_ctl[dbg_pkg::ctl_range] & dbg_pkg::hwbrk_range_en;
  assign fetch_mode = brk_ctl[dbg_pkg::ctl_inst_en] &
                      brk_ctl[dbg_pkg::ctl_mode_rd] & ~brk_ctl[dbg_pkg::ctl_mode_wr];
  assign d_wr       = |eu_mb_wr;

  // Data side, own copy of each compare for timing
  assign equ_d_addr0 = eu_mb_en & (eu_mab == brk_addr0) & ~range_mode;
  assign equ_d_addr1 = eu_mb_en & (eu_mab == brk_addr1) & ~range_mode;
  assign equ_d_range = eu_mb_en & (eu_mab >= brk_addr0) & (eu_mab <= brk_addr1) & range_mode;

  // Fetch address is valid one cycle after the request
  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      fe_mb_en_q <= 1'b0;
    end else begin
      fe_mb_en_q <= fe_mb_en;
    end
  end

  assign equ_i_addr0 = fe_mb_en_q & (pc == brk_addr0) & ~range_mode;
  assign equ_i_addr1 = fe_mb_en_q & (pc == brk_addr1) & ~range_mode;
  assign equ_i_range = fe_mb_en_q & (pc >= brk_addr0) & (pc <= brk_addr1) & range_mode;

  //==========================================================
  // Access detection
  //==========================================================
  assign i_addr0_rd = equ_i_addr0 & fetch_mode;   // Fetches only in mode 01
  assign i_addr1_rd = equ_i_addr1 & fetch_mode;
  assign i_range_rd = equ_i_range & fetch_mode;

  assign d_addr0_wr = equ_d_addr0 & ~brk_ctl[dbg_pkg::ctl_inst_en] & d_wr;
  assign d_addr1_wr = equ_d_addr1 & ~brk_ctl[dbg_pkg::ctl_inst_en] & d_wr;
  assign d_range_wr = equ_d_range & ~brk_ctl[dbg_pkg::ctl_inst_en] & d_wr;

  // Data reads held until the instruction ends
  // A write-back in the last cycle turns it into a write
  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      d_rd_trig <= 3'h0;
    end else if (exec_done) begin
      d_rd_trig <= 3'h0;
    end else begin
      d_rd_trig <= d_rd_trig |
                   ({equ_d_range, equ_d_addr1, equ_d_addr0} &
                    {3{~brk_ctl[dbg_pkg::ctl_inst_en] & ~d_wr}});
    end
  end

  assign d_addr0_rd = d_rd_trig[0] & exec_done & ~d_addr0_wr;
  assign d_addr1_rd = d_rd_trig[1] & exec_done & ~d_addr1_wr;
  assign d_range_rd = d_rd_trig[2] & exec_done & ~d_range_wr;

  //==========================================================
  // Flags and halt
  //==========================================================
  assign stat_set = {brk_ctl[dbg_pkg::ctl_mode_wr] & d_range_wr & dbg_pkg::hwbrk_range_en,
                     brk_ctl[dbg_pkg::ctl_mode_rd] & (d_range_rd | i_range_rd) &
                       dbg_pkg::hwbrk_range_en,
                     brk_ctl[dbg_pkg::ctl_mode_wr] & d_addr1_wr,
                     brk_ctl[dbg_pkg::ctl_mode_rd] & (d_addr1_rd | i_addr1_rd),
                     brk_ctl[dbg_pkg::ctl_mode_wr] & d_addr0_wr,
                     brk_ctl[dbg_pkg::ctl_mode_rd] & (d_addr0_rd | i_addr0_rd)};

  assign brk_pnd  = |brk_stat;
  assign brk_halt = brk_ctl[dbg_pkg::ctl_brk_en] & (|stat_set);

  //==========================================================
  // Assertions
  //==========================================================
  a_wr_onehot : assert property (@(posedge mclk) disable iff (por)
    $onehot0(brk_reg_wr));

  // Range flags never appear without range support
  a_no_range : assert property (@(posedge mclk) disable iff (por)
    !dbg_pkg::hwbrk_range_en |-> (brk_stat[5:4] == 2'b00));

endmodule

`default_nettype wire

// File: dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  //==========================================================
  // Build options
  //==========================================================
  localparam int num_hwbrk = 2;                   // Breakpoint units, 1 to 4
  localparam logic hwbrk_range_en = 1'b1;         // Range compare support

  //==========================================================
  // Host register map
  //==========================================================
  localparam logic [5:0] cpu_ctl_addr  = 6'h01;   // HALT / RUN commands
  localparam logic [5:0] cpu_stat_addr = 6'h02;   // Halt state and pending lines
  localparam logic [5:0] brk_base_addr = 6'h08;   // Unit n at base + 4n

  // Register slots inside one unit
  localparam int brk_ctl_idx   = 0;
  localparam int brk_stat_idx  = 1;
  localparam int brk_addr0_idx = 2;
  localparam int brk_addr1_idx = 3;

  // CPU_CTL command bits
  localparam int cpu_ctl_halt = 0;
  localparam int cpu_ctl_run  = 1;

  // BRK_CTL bit positions
  localparam int ctl_mode_rd = 0;                 // Match reads
  localparam int ctl_mode_wr = 1;                 // Match writes
  localparam int ctl_brk_en  = 2;                 // Halt on match
  localparam int ctl_inst_en = 3;                 // Watch fetches, not data
  localparam int ctl_range   = 4;                 // addr0..addr1 range compare

  //==========================================================
  // Debug data word, two decodings of the same 16 bits
  //==========================================================
  // BRK_CTL write layout, or BRK_STAT clear mask
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [10:0] rsvd;
      logic        range_mode;
      logic        inst_en;
      logic        break_en;
      logic [1:0]  access_mode;                   // 00 off, 01 rd, 10 wr, 11 both
    } ctl;
    struct packed {
      logic [9:0]  rsvd;
      logic        range_wr;
      logic        range_rd;
      logic        addr1_wr;
      logic        addr1_rd;
      logic        addr0_wr;
      logic        addr0_rd;
    } stat;
  } dbg_word_u;

endpackage

`default_nettype wire

// File: dbg_top.sv
`default_nettype none

module dbg_top (
  input  logic        mclk,
  input  logic        por,
  // Host register port
  input  logic [5:0]  dbg_addr,
  input  logic [15:0] dbg_din,
  input  logic        dbg_wr,
  input  logic        dbg_rd,
  // CPU bus observation
  input  logic [15:0] eu_mab,
  input  logic        eu_mb_en,
  input  logic [1:0]  eu_mb_wr,
  input  logic        exec_done,
  input  logic        fe_mb_en,
  input  logic [15:0] pc,
  // Results
  output logic [15:0] dbg_dout,
  output logic        dbg_halt_cmd
);

  //==========================================================
  // Internal wiring
  //==========================================================
  logic [dbg_pkg::num_hwbrk-1:0]    brk_halt;      // One per unit
  logic [dbg_pkg::num_hwbrk-1:0]    brk_pnd;
  logic [16*dbg_pkg::num_hwbrk-1:0] brk_dout;      // 16 bits per unit
  logic [4*dbg_pkg::num_hwbrk-1:0]  brk_reg_rd;    // 4 selects per unit
  logic [4*dbg_pkg::num_hwbrk-1:0]  brk_reg_wr;

  //==========================================================
  // Register port and halt control
  //==========================================================
  dbg_ctrl u_ctrl (
    .mclk         (mclk),
    .por          (por),
    .dbg_addr     (dbg_addr),
    .dbg_din      (dbg_din),
    .dbg_wr       (dbg_wr),
    .dbg_rd       (dbg_rd),
    .brk_halt     (brk_halt),
    .brk_pnd      (brk_pnd),
    .brk_dout     (brk_dout),
    .brk_reg_rd   (brk_reg_rd),
    .brk_reg_wr   (brk_reg_wr),
    .dbg_dout     (dbg_dout),
    .dbg_halt_cmd (dbg_halt_cmd)
  );

  //==========================================================
  // Breakpoint units
  //==========================================================
  for (genvar n = 0; n < dbg_pkg::num_hwbrk; n++) begin : g_hwbrk
    dbg_hwbrk u_hwbrk (
      .mclk       (mclk),
      .por        (por),
      .brk_reg_rd (brk_reg_rd[4*n +: 4]),          // Own register slice
      .brk_reg_wr (brk_reg_wr[4*n +: 4]),
      .dbg_din    (dbg_din),
      .eu_mab     (eu_mab),                        // Shared CPU buses
      .eu_mb_en   (eu_mb_en),
      .eu_mb_wr   (eu_mb_wr),
      .exec_done  (exec_done),
      .fe_mb_en   (fe_mb_en),
      .pc         (pc),
      .brk_halt   (brk_halt[n]),
      .brk_pnd    (brk_pnd[n]),
      .brk_dout   (brk_dout[16*n +: 16])
    );
  end

endmodule

`default_nettype wire

// File: sim.f
dbg_pkg.sv
dbg_hwbrk.sv
dbg_ctrl.sv
dbg_top.sv
tb_dbg.sv

// File: tb_dbg.sv
`default_nettype none

module tb_dbg;
  timeunit 1ns;
  timeprecision 1ps;

  //==========================================================
  // Run length
  //==========================================================
  localparam int num_tests   = 5;
  localparam int clk_period  = 40;
  localparam int wdog_cycles = num_tests * 200 + 50;   // Watchdog budget in clocks

  logic        mclk, por;
  logic [5:0]  dbg_addr;
  logic [15:0] dbg_din;
  logic        dbg_wr, dbg_rd;
  logic [15:0] eu_mab;
  logic        eu_mb_en;
  logic [1:0]  eu_mb_wr;
  logic        exec_done, fe_mb_en;
  logic [15:0] pc;
  logic [15:0] dbg_dout;
  logic        dbg_halt_cmd;

  int          err_cnt;
  int          chk_cnt;
  logic [15:0] lfsr_q;                                 // Stimulus generator state

  dbg_top dut0 (
    .mclk(mclk), .por(por),
    .dbg_addr(dbg_addr), .dbg_din(dbg_din), .dbg_wr(dbg_wr), .dbg_rd(dbg_rd),
    .eu_mab(eu_mab), .eu_mb_en(eu_mb_en), .eu_mb_wr(eu_mb_wr),
    .exec_done(exec_done), .fe_mb_en(fe_mb_en), .pc(pc),
    .dbg_dout(dbg_dout), .dbg_halt_cmd(dbg_halt_cmd)
  );

  initial begin
    mclk = 1'b0;
    forever #(clk_period/2) mclk = ~mclk;
  end

  //==========================================================
  // Random words and register addresses
  //==========================================================
  function automatic logic [15:0] galois_step(input logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hB400;              // x^16+x^14+x^13+x^11+1
    return s >> 1;
  endfunction

  task automatic take_word(output logic [15:0] w);
    for (int i = 0; i < 16; i++) begin
      w[i]   = lfsr_q[0];                              // One step per bit
      lfsr_q = galois_step(lfsr_q);
    end
  endtask

  function automatic logic [5:0] brk_reg_addr(input int unit, input int idx);
    logic [5:0] a;
    a = dbg_pkg::brk_base_addr + 6'(4 * unit + idx);   // Four slots per unit
    return a;
  endfunction

  //==========================================================
  // Compare tasks
  //==========================================================
  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Field by field, so a wrong flag is named
  task automatic check_stat(input string name, input logic [15:0] got_raw,
                            input dbg_pkg::dbg_word_u exp);
    dbg_pkg::dbg_word_u got;
    got.raw = got_raw;
    check_word({name, ".rsvd"}, 16'(got.stat.rsvd), 16'(exp.stat.rsvd));
    check_bit({name, ".range_wr"}, got.stat.range_wr, exp.stat.range_wr);
    check_bit({name, ".range_rd"}, got.stat.range_rd, exp.stat.range_rd);
    check_bit({name, ".addr1_wr"}, got.stat.addr1_wr, exp.stat.addr1_wr);
    check_bit({name, ".addr1_rd"}, got.stat.addr1_rd, exp.stat.addr1_rd);
    check_bit({name, ".addr0_wr"}, got.stat.addr0_wr, exp.stat.addr0_wr);
    check_bit({name, ".addr0_rd"}, got.stat.addr0_rd, exp.stat.addr0_rd);
  endtask

  //==========================================================
  // Host port and CPU bus drivers
  //==========================================================
  task automatic host_write(input logic [5:0] addr, input logic [15:0] data);
    @(negedge mclk);
    dbg_addr = addr;
    dbg_din  = data;
    dbg_wr   = 1'b1;                                   // Taken on next rising edge
    @(negedge mclk);
    dbg_wr   = 1'b0;
    dbg_addr = 6'h00;
    dbg_din  = 16'h0000;
  endtask

  task automatic host_read(input logic [5:0] addr, output logic [15:0] data);
    @(negedge mclk);
    dbg_addr = addr;
    dbg_rd   = 1'b1;
    #(clk_period/4);
    data     = dbg_dout;                               // Combinational, mid low phase
    @(negedge mclk);
    dbg_rd   = 1'b0;
    dbg_addr = 6'h00;
  endtask

  task automatic bus_idle();
    eu_mab    = 16'h0000;
    eu_mb_en  = 1'b0;
    eu_mb_wr  = 2'b00;
    exec_done = 1'b0;
    fe_mb_en  = 1'b0;
    pc        = 16'h0000;
  endtask

  task automatic bus_write(input logic [15:0] addr);
    @(negedge mclk);
    eu_mab   = addr;
    eu_mb_en = 1'b1;
    eu_mb_wr = 2'b11;
    @(negedge mclk);
    bus_idle();
  endtask

  // Data read, then exec_done with an optional write-back
  task automatic bus_read_exec(input logic [15:0] addr, input logic wr_back);
    @(negedge mclk);
    eu_mab   = addr;
    eu_mb_en = 1'b1;
    eu_mb_wr = 2'b00;
    @(negedge mclk);
    exec_done = 1'b1;
    eu_mb_en  = wr_back;
    eu_mb_wr  = wr_back ? 2'b11 : 2'b00;
    @(negedge mclk);
    bus_idle();
  endtask

  task automatic fetch_at(input logic [15:0] addr);
    @(negedge mclk);
    fe_mb_en = 1'b1;
    @(negedge mclk);
    fe_mb_en = 1'b0;
    pc       = addr;                                   // Valid the cycle after request
    @(negedge mclk);
    bus_idle();
  endtask

  task automatic expect_unit_stat(input int unit, input dbg_pkg::dbg_word_u exp);
    logic [15:0] rd;
    host_read(brk_reg_addr(unit, dbg_pkg::brk_stat_idx), rd);
    check_stat($sformatf("brk_stat%0d", unit), rd, exp);
  endtask

  //==========================================================
  // Directed tests
  //==========================================================
  task automatic regs_readback();
    logic [15:0] v0, v1, rd;
    for (int u = 0; u < dbg_pkg::num_hwbrk; u++) begin
      take_word(v0);
      take_word(v1);
      host_write(brk_reg_addr(u, dbg_pkg::brk_addr0_idx), v0);
      host_write(brk_reg_addr(u, dbg_pkg::brk_addr1_idx), v1);
      host_read(brk_reg_addr(u, dbg_pkg::brk_addr0_idx), rd);
      check_word("brk_addr0", rd, v0);
      host_read(brk_reg_addr(u, dbg_pkg::brk_addr1_idx), rd);
      check_word("brk_addr1", rd, v1);
      host_write(brk_reg_addr(u, dbg_pkg::brk_ctl_idx), 16'hFFFF);
      host_read(brk_reg_addr(u, dbg_pkg::brk_ctl_idx), rd);
      check_word("brk_ctl", rd, 16'h001F);             // Five bits, range built in
      host_write(brk_reg_addr(u, dbg_pkg::brk_ctl_idx), 16'h0000);
      host_read(brk_reg_addr(u, dbg_pkg::brk_stat_idx), rd);
      check_word("brk_stat", rd, 16'h0000);
    end
    host_read(6'h03, rd);                              // Hole in the map
    check_word("dbg_dout", rd, 16'h0000);
    host_read(brk_reg_addr(dbg_pkg::num_hwbrk, 0), rd);  // Past the last unit
    check_word("dbg_dout", rd, 16'h0000);
    @(negedge mclk);
    dbg_addr = brk_reg_addr(0, dbg_pkg::brk_addr0_idx);  // Selected but no strobe
    #(clk_period/4);
    check_word("dbg_dout", dbg_dout, 16'h0000);
    @(negedge mclk);
    dbg_addr = 6'h00;
  endtask

  task automatic data_watchpoint();
    dbg_pkg::dbg_word_u w, exp;
    logic [15:0] a, rd, cs;
    take_word(a);
    w.raw = 16'h0000;
    w.ctl.access_mode = 2'b10;                         // Writes only, no halt
    host_write(brk_reg_addr(0, dbg_pkg::brk_addr0_idx), a);
    host_write(brk_reg_addr(0, dbg_pkg::brk_addr1_idx), a ^ 16'h5A5A);
    host_write(brk_reg_addr(0, dbg_pkg::brk_ctl_idx), w.raw);
    bus_write(a);
    exp.raw = 16'h0000;
    exp.stat.addr0_wr = 1'b1;
    expect_unit_stat(0, exp);
    cs = 16'h0000;
    cs[2] = 1'b1;                                      // Any pending
    cs[4] = 1'b1;                                      // Unit 0 pending
    host_read(dbg_pkg::cpu_stat_addr, rd);
    check_word("cpu_stat", rd, cs);
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    w.raw = 16'h0000;
    w.stat.addr0_wr = 1'b1;                            // Clear mask
    host_write(brk_reg_addr(0, dbg_pkg::brk_stat_idx), w.raw);
    exp.raw = 16'h0000;
    expect_unit_stat(0, exp);
    host_read(dbg_pkg::cpu_stat_addr, rd);
    check_word("cpu_stat", rd, 16'h0000);
    host_write(brk_reg_addr(0, dbg_pkg::brk_ctl_idx), 16'h0000);
  endtask

  task automatic fetch_breakpoint();
    dbg_pkg::dbg_word_u w, exp;
    logic [15:0] p, rd, cs;
    take_word(p);
    w.raw = 16'h0000;
    w.ctl.inst_en     = 1'b1;
    w.ctl.break_en    = 1'b1;
    w.ctl.access_mode = 2'b01;
    host_write(brk_reg_addr(1, dbg_pkg::brk_addr0_idx), p);
    host_write(brk_reg_addr(1, dbg_pkg::brk_addr1_idx), p ^ 16'h0003);
    host_write(brk_reg_addr(1, dbg_pkg::brk_ctl_idx), w.raw);
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    fetch_at(p);
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);
    exp.raw = 16'h0000;
    exp.stat.addr0_rd = 1'b1;
    expect_unit_stat(1, exp);
    cs = 16'h0000;
    cs[0] = 1'b1;                                      // Halted
    cs[2] = 1'b1;
    cs[5] = 1'b1;                                      // Unit 1 pending
    host_read(dbg_pkg::cpu_stat_addr, rd);
    check_word("cpu_stat", rd, cs);
    host_write(dbg_pkg::cpu_ctl_addr, 16'(1 << dbg_pkg::cpu_ctl_run));
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    host_write(dbg_pkg::cpu_ctl_addr, 16'(1 << dbg_pkg::cpu_ctl_halt));
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);
    host_write(dbg_pkg::cpu_ctl_addr, 16'(1 << dbg_pkg::cpu_ctl_run));
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    host_write(dbg_pkg::cpu_ctl_addr, 16'h0003);       // Both bits, HALT wins
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);
    host_write(dbg_pkg::cpu_ctl_addr, 16'(1 << dbg_pkg::cpu_ctl_run));
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    host_write(brk_reg_addr(1, dbg_pkg::brk_ctl_idx), 16'h0000);
    host_write(brk_reg_addr(1, dbg_pkg::brk_stat_idx), 16'h003F);
    exp.raw = 16'h0000;
    expect_unit_stat(1, exp);
  endtask

  task automatic read_vs_rmw();
    dbg_pkg::dbg_word_u w, exp;
    logic [15:0] d;
    take_word(d);
    w.raw = 16'h0000;
    w.ctl.access_mode = 2'b11;                         // Reads and writes
    host_write(brk_reg_addr(0, dbg_pkg::brk_addr0_idx), ~d);
    host_write(brk_reg_addr(0, dbg_pkg::brk_addr1_idx), d);
    host_write(brk_reg_addr(0, dbg_pkg::brk_ctl_idx), w.raw);
    bus_read_exec(d, 1'b0);
    exp.raw = 16'h0000;
    exp.stat.addr1_rd = 1'b1;
    expect_unit_stat(0, exp);
    host_write(brk_reg_addr(0, dbg_pkg::brk_stat_idx), 16'h003F);
    bus_read_exec(d, 1'b1);                            // Write-back in exec_done cycle
    exp.raw = 16'h0000;
    exp.stat.addr1_wr = 1'b1;
    expect_unit_stat(0, exp);
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
    host_write(brk_reg_addr(0, dbg_pkg::brk_stat_idx), 16'h003F);
    host_write(brk_reg_addr(0, dbg_pkg::brk_ctl_idx), 16'h0000);
  endtask

  task automatic range_and_modes();
    dbg_pkg::dbg_word_u w, exp;
    logic [15:0] r, lo, hi;
    take_word(r);
    lo = (r & 16'h7FFF) | 16'h0100;                    // Room below and above
    hi = lo + 16'h0040;
    w.raw = 16'h0000;
    w.ctl.range_mode  = 1'b1;
    w.ctl.access_mode = 2'b10;
    host_write(brk_reg_addr(1, dbg_pkg::brk_addr0_idx), lo);
    host_write(brk_reg_addr(1, dbg_pkg::brk_addr1_idx), hi);
    host_write(brk_reg_addr(1, dbg_pkg::brk_ctl_idx), w.raw);
    bus_write(lo + 16'h0010);
    exp.raw = 16'h0000;
    exp.stat.range_wr = 1'b1;
    expect_unit_stat(1, exp);
    host_write(brk_reg_addr(1, dbg_pkg::brk_stat_idx), 16'h003F);
    bus_write(hi + 16'h0001);
    bus_write(lo - 16'h0001);
    exp.raw = 16'h0000;
    expect_unit_stat(1, exp);
    host_write(brk_reg_addr(1, dbg_pkg::brk_ctl_idx), 16'h0000);  // Mode 00
    bus_write(lo);
    bus_read_exec(lo, 1'b0);
    fetch_at(lo);
    expect_unit_stat(1, exp);
    w.raw = 16'h0000;
    w.ctl.inst_en     = 1'b1;
    w.ctl.access_mode = 2'b10;                         // Write mode ignores fetches
    host_write(brk_reg_addr(1, dbg_pkg::brk_ctl_idx), w.raw);
    fetch_at(lo);
    expect_unit_stat(1, exp);
    w.ctl.access_mode = 2'b11;                         // Both, fetches still ignored
    host_write(brk_reg_addr(1, dbg_pkg::brk_ctl_idx), w.raw);
    fetch_at(lo);
    expect_unit_stat(1, exp);
    host_write(brk_reg_addr(1, dbg_pkg::brk_ctl_idx), 16'h0000);
  endtask

  //==========================================================
  // Sequence and watchdog
  //==========================================================
  initial begin
    por      = 1'b1;
    dbg_addr = 6'h00;
    dbg_din  = 16'h0000;
    dbg_wr   = 1'b0;
    dbg_rd   = 1'b0;
    bus_idle();
    err_cnt  = 0;
    chk_cnt  = 0;
    lfsr_q   = 16'd41812;
    repeat (2) @(posedge mclk);
    @(negedge mclk);
    por = 1'b0;
    regs_readback();
    data_watchpoint();
    fetch_breakpoint();
    read_vs_rmw();
    range_and_modes();
    repeat (2) @(negedge mclk);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(wdog_cycles * clk_period);
    $display("Watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
